//--- hw/mips_pkg.sv
package mips_pkg;

    // Primary opcode field in instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTIU = 6'h0B,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    // Function field of R-type words in instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // Boot address in kseg1
    localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;

endpackage

//--- hw/mips_decode_if.sv
`timescale 1ns/1ps

interface mips_decode_if;
    logic              reg_dst;
    logic              alu_src_imm;
    logic              imm_zero_ext;
    logic              mem_read;
    logic              mem_write;
    logic              mem_to_reg;
    logic              reg_write;
    logic              link;
    logic              branch_eq;
    logic              branch_ne;
    logic              jump;
    logic              jump_reg;
    mips_pkg::alu_op_e alu_op;

    modport decoder (
        output reg_dst, alu_src_imm, imm_zero_ext, mem_read, mem_write, mem_to_reg,
        output reg_write, link, branch_eq, branch_ne, jump, jump_reg, alu_op
    );

    modport datapath (
        input reg_dst, alu_src_imm, imm_zero_ext, mem_read, mem_write, mem_to_reg,
        input reg_write, link, branch_eq, branch_ne, jump, jump_reg, alu_op
    );
endinterface

//--- hw/mips_decoder.sv
`timescale 1ns/1ps

module mips_decoder (
    input  logic [31:0]     instr,
    mips_decode_if.decoder  dec
);
    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;

    assign opcode = mips_pkg::opcode_e'(instr[31:26]);
    assign funct  = mips_pkg::funct_e'(instr[5:0]);

    always_comb begin
        // Default is a no-op with every write disabled
        dec.reg_dst      = 1'b0;
        dec.alu_src_imm  = 1'b0;
        dec.imm_zero_ext = 1'b0;
        dec.mem_read     = 1'b0;
        dec.mem_write    = 1'b0;
        dec.mem_to_reg   = 1'b0;
        dec.reg_write    = 1'b0;
        dec.link         = 1'b0;
        dec.branch_eq    = 1'b0;
        dec.branch_ne    = 1'b0;
        dec.jump         = 1'b0;
        dec.jump_reg     = 1'b0;
        dec.alu_op       = mips_pkg::ALU_ADD;

        case (opcode)
            mips_pkg::OP_RTYPE: begin
                dec.reg_dst   = 1'b1;
                dec.reg_write = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  dec.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLTU: dec.alu_op = mips_pkg::ALU_SLTU;
                    // Shift amount comes from the shamt field
                    mips_pkg::FN_SLL:  dec.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  dec.alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_JR: begin
                        dec.reg_write = 1'b0;
                        dec.jump_reg  = 1'b1;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
                dec.alu_src_imm  = 1'b1;
                dec.imm_zero_ext = 1'b1;
                dec.reg_write    = 1'b1;
                case (opcode)
                    mips_pkg::OP_ANDI: dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:  dec.alu_op = mips_pkg::ALU_OR;
                    default:           dec.alu_op = mips_pkg::ALU_XOR;
                endcase
            end
            mips_pkg::OP_LUI: begin
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                dec.alu_op      = mips_pkg::ALU_LUI;
            end
            mips_pkg::OP_LW: begin
                dec.alu_src_imm = 1'b1;
                dec.mem_read    = 1'b1;
                dec.mem_to_reg  = 1'b1;
                dec.reg_write   = 1'b1;
            end
            mips_pkg::OP_SW: begin
                dec.alu_src_imm = 1'b1;
                dec.mem_write   = 1'b1;
            end
            // Branches compare rs and rt through the ALU zero flag
            mips_pkg::OP_BEQ: begin
                dec.branch_eq = 1'b1;
                dec.alu_op    = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_BNE: begin
                dec.branch_ne = 1'b1;
                dec.alu_op    = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_J: dec.jump = 1'b1;
            mips_pkg::OP_JAL: begin
                dec.jump      = 1'b1;
                dec.link      = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: dec.alu_op = mips_pkg::ALU_ADD;
        endcase
    end

endmodule

//--- hw/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile #(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clk_enable,
    input  logic [4:0]  rd_index_a,
    input  logic [4:0]  rd_index_b,
    input  logic        wr_enable,
    input  logic [4:0]  wr_index,
    input  logic [31:0] wr_data,
    output logic [31:0] rd_data_a,
    output logic [31:0] rd_data_b,
    output logic [31:0] v0
);
    localparam int IDX_W = $clog2(REG_COUNT);

    logic [31:0] regs [REG_COUNT];

    // Upper index bits drop out in reduced variants
    assign rd_data_a = regs[rd_index_a[IDX_W-1:0]];
    assign rd_data_b = regs[rd_index_b[IDX_W-1:0]];
    assign v0        = regs[2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable && wr_enable && wr_index[IDX_W-1:0] != '0) begin
            // $0 is never written so it reads back as zero
            regs[wr_index[IDX_W-1:0]] <= wr_data;
        end
    end

endmodule

//--- hw/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::alu_op_e alu_op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  logic [4:0]        shamt,
    output logic [31:0]       result,
    output logic              zero
);

    always_comb begin
        case (alu_op)
            mips_pkg::ALU_ADD:  result = a + b;
            mips_pkg::ALU_SUB:  result = a - b;
            mips_pkg::ALU_AND:  result = a & b;
            mips_pkg::ALU_OR:   result = a | b;
            mips_pkg::ALU_XOR:  result = a ^ b;
            mips_pkg::ALU_SLTU: result = {31'd0, a < b};
            // Shifts act on rt
            mips_pkg::ALU_SLL:  result = b << shamt;
            mips_pkg::ALU_SRL:  result = b >> shamt;
            mips_pkg::ALU_LUI:  result = {b[15:0], 16'd0};
            default:            result = '0;
        endcase
    end

    // Equality test for BEQ and BNE
    assign zero = (result == 32'd0);

endmodule

//--- hw/mips_pc.sv
`timescale 1ns/1ps

module mips_pc (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            clk_enable,
    mips_decode_if.datapath dec,
    input  logic [25:0]     instr_index,
    input  logic [31:0]     imm_ext,
    input  logic [31:0]     reg_a,
    input  logic            zero,
    output logic [31:0]     pc,
    output logic [31:0]     pc_plus4,
    output logic            active
);
    logic        branch_taken;
    logic        halted;
    logic [31:0] next_pc;

    assign pc_plus4     = pc + 32'd4;
    assign branch_taken = (dec.branch_eq && zero) || (dec.branch_ne && !zero);

    // No delay slot so the target is taken directly
    always_comb begin
        if (branch_taken) begin
            next_pc = pc_plus4 + {imm_ext[29:0], 2'b00};
        end else if (dec.jump) begin
            next_pc = {pc_plus4[31:28], instr_index, 2'b00};
        end else if (dec.jump_reg) begin
            next_pc = reg_a;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= mips_pkg::RESET_VECTOR;
            active <= 1'b0;
            halted <= 1'b0;
        end else if (clk_enable) begin
            if (active) begin
                pc <= next_pc;
                // Jump to address 0 ends execution
                if (next_pc == 32'd0) begin
                    active <= 1'b0;
                    halted <= 1'b1;
                end
            end else if (!halted) begin
                active <= 1'b1;
            end
        end
    end

endmodule

//--- hw/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard #(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clk_enable,
    output logic        active,
    output logic [31:0] register_v0,

    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    logic [31:0] imm_ext;
    logic [31:0] reg_a;
    logic [31:0] reg_b;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [4:0]  wr_index;
    logic [31:0] wr_data;
    logic [31:0] pc_plus4;

    mips_decode_if dec ();

    assign rs  = instr_readdata[25:21];
    assign rt  = instr_readdata[20:16];
    assign rd  = instr_readdata[15:11];
    assign imm = instr_readdata[15:0];

    mips_decoder u_decoder (
        .instr (instr_readdata),
        .dec   (dec)
    );

    // Logic immediates are zero-extended and the rest sign-extended
    assign imm_ext = dec.imm_zero_ext ? {16'd0, imm} : {{16{imm[15]}}, imm};
    assign alu_b   = dec.alu_src_imm ? imm_ext : reg_b;

    // JAL links into $31
    assign wr_index = dec.link ? 5'd31 : (dec.reg_dst ? rd : rt);

    always_comb begin
        if (dec.link) begin
            wr_data = pc_plus4;
        end else if (dec.mem_to_reg) begin
            wr_data = data_readdata;
        end else begin
            wr_data = alu_result;
        end
    end

    mips_regfile #(
        .REG_COUNT (REG_COUNT)
    ) u_regfile (
        .clk        (clk),
        .arst_n     (arst_n),
        .clk_enable (clk_enable),
        .rd_index_a (rs),
        .rd_index_b (rt),
        .wr_enable  (dec.reg_write && active),
        .wr_index   (wr_index),
        .wr_data    (wr_data),
        .rd_data_a  (reg_a),
        .rd_data_b  (reg_b),
        .v0         (register_v0)
    );

    mips_alu u_alu (
        .alu_op (dec.alu_op),
        .a      (reg_a),
        .b      (alu_b),
        .shamt  (instr_readdata[10:6]),
        .result (alu_result),
        .zero   (alu_zero)
    );

    mips_pc u_pc (
        .clk         (clk),
        .arst_n      (arst_n),
        .clk_enable  (clk_enable),
        .dec         (dec),
        .instr_index (instr_readdata[25:0]),
        .imm_ext     (imm_ext),
        .reg_a       (reg_a),
        .zero        (alu_zero),
        .pc          (instr_address),
        .pc_plus4    (pc_plus4),
        .active      (active)
    );

    // Memory strobes only while running
    assign data_address   = alu_result;
    assign data_writedata = reg_b;
    assign data_write     = dec.mem_write && active;
    assign data_read      = dec.mem_read && active;

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- testbench/mips_asserts.sv
`timescale 1ns/1ps

module mips_asserts (
    input logic        clk,
    input logic        arst_n,
    input logic        clk_enable,
    input logic        active,
    input logic [31:0] instr_address,
    input logic        data_write,
    input logic        data_read
);
    int error_count = 0;

    idle_in_reset: assert property (@(posedge clk) !arst_n |-> !active)
        else begin
            error_count++;
            $error("active is high while reset is asserted");
        end

    one_data_strobe: assert property (@(posedge clk) !(data_write && data_read))
        else begin
            error_count++;
            $error("data_write and data_read are high together");
        end

    // A disabled edge leaves the PC where it was
    pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
        !clk_enable |=> $stable(instr_address))
        else begin
            error_count++;
            $error("instr_address moved while clk_enable was low");
        end

    halt_at_zero: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(active) |-> instr_address == 32'd0)
        else begin
            error_count++;
            $error("active fell with instr_address not zero");
        end

    halt_holds: assert property (@(posedge clk) disable iff (!arst_n)
        (!active && instr_address == 32'd0) |=> instr_address == 32'd0)
        else begin
            error_count++;
            $error("instr_address left zero after the halt");
        end

endmodule

bind mips_cpu_harvard mips_asserts u_asserts (
    .clk           (clk),
    .arst_n        (arst_n),
    .clk_enable    (clk_enable),
    .active        (active),
    .instr_address (instr_address),
    .data_write    (data_write),
    .data_read     (data_read)
);

//--- testbench/mips_tb.sv
`timescale 1ns/1ps

module mips_tb;
    localparam int CLK_PERIOD_NS = 4;
    localparam int STALL_CYCLES  = 6;
    // Words of every program in test order
    localparam int PROGRAM_WORDS = 1 + 15 + 6 + 13 + 2 * 6 + 10 * 8;
    localparam int RUN_COUNT     = 16;
    // Reset pulse, start-up and halt around each run
    localparam int RUN_OVERHEAD  = 8;
    localparam int WATCHDOG_NS   = 2 * CLK_PERIOD_NS
        * (PROGRAM_WORDS + STALL_CYCLES + RUN_COUNT * RUN_OVERHEAD);

    logic        clk;
    logic        arst_n;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] imem_offset;
    logic [31:0] rng_state;
    int          prog_len;
    int          read_strobes;
    int          test_errors;
    int          pass_count;
    int          fail_count;
    string       current_test;

    tb_clock #(
        .PERIOD_NS (CLK_PERIOD_NS)
    ) u_clock (
        .clk (clk)
    );

    mips_cpu_harvard #(
        .REG_COUNT (32)
    ) dut0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    // Program image starts at the reset vector and anything outside reads as a NOP
    assign imem_offset    = instr_address - mips_pkg::RESET_VECTOR;
    assign instr_readdata = (imem_offset < 32'd256) ? imem[imem_offset[7:2]] : 32'd0;
    assign data_readdata  = dmem[data_address[7:2]];

    // Data memory refills with an address pattern during reset
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i[5:0]] <= 32'hDEAD_0000 ^ (i * 32'h0001_0203);
            end
        end else if (data_write && clk_enable) begin
            dmem[data_address[7:2]] <= data_writedata;
        end
    end

    // Data reads seen on enabled edges
    always @(posedge clk) begin
        if (arst_n && clk_enable && data_read) begin
            read_strobes++;
        end
    end

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] zext16(input logic [15:0] v);
        return {16'd0, v};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] rtype_word(input mips_pkg::funct_e fn, input int rs,
                                               input int rt, input int rd, input int shamt);
        return {mips_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], fn};
    endfunction

    function automatic logic [31:0] itype_word(input mips_pkg::opcode_e op, input int rs,
                                               input int rt, input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] jump_word(input mips_pkg::opcode_e op,
                                              input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", current_test, expected, actual);
            test_errors++;
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < 64; i++) begin
            imem[i[5:0]] = 32'd0;
        end
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        imem[prog_len[5:0]] = word;
        prog_len++;
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors  = 0;
        read_strobes = 0;
        clear_program();
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %s finished with %0d errors", current_test, test_errors);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n = 1'b0;
        repeat (2) @(negedge clk);
        check_value(32'd0, {31'd0, active});
        check_value(mips_pkg::RESET_VECTOR, instr_address);
        arst_n = 1'b1;
        // First enabled edge after release raises active
        @(negedge clk);
    endtask

    task automatic hold_clock_enable(input logic [5:0] watch);
        logic [31:0] pc_snap;
        logic [31:0] v0_snap;
        logic [31:0] mem_snap;
        clk_enable = 1'b0;
        pc_snap    = instr_address;
        v0_snap    = register_v0;
        mem_snap   = dmem[watch];
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            check_value(pc_snap, instr_address);
            check_value(v0_snap, register_v0);
            check_value(mem_snap, dmem[watch]);
        end
        clk_enable = 1'b1;
    endtask

    task automatic run_to_halt(input int stall_at, input logic [5:0] watch);
        int cycle;
        cycle = 0;
        while (active) begin
            if (cycle == stall_at) begin
                hold_clock_enable(watch);
            end
            @(negedge clk);
            cycle++;
        end
    endtask

    task automatic load_store_program();
        emit(itype_word(mips_pkg::OP_ADDIU, 0, 8, 16'h0040));
        emit(itype_word(mips_pkg::OP_LUI, 0, 9, 16'h1234));
        emit(itype_word(mips_pkg::OP_ORI, 9, 9, 16'h5678));
        emit(itype_word(mips_pkg::OP_SW, 8, 9, 16'h0008));
        emit(itype_word(mips_pkg::OP_LW, 8, 2, 16'h0008));
        emit(rtype_word(mips_pkg::FN_JR, 0, 0, 0, 0));
    endtask

    task automatic reset_and_halt();
        begin_test("reset_halt");
        emit(rtype_word(mips_pkg::FN_JR, 0, 0, 0, 0));
        apply_reset();
        check_value(32'd1, {31'd0, active});
        check_value(mips_pkg::RESET_VECTOR, instr_address);
        run_to_halt(-1, 6'd0);
        check_value(32'd0, instr_address);
        end_test();
    endtask

    task automatic alu_instructions();
        logic [31:0] m [32];
        begin_test("alu_ops");
        emit(itype_word(mips_pkg::OP_ADDIU, 0, 8, 16'hFFF3));
        emit(itype_word(mips_pkg::OP_ANDI, 8, 9, 16'h0FF0));
        emit(itype_word(mips_pkg::OP_ORI, 9, 10, 16'h8001));
        emit(itype_word(mips_pkg::OP_XORI, 10, 11, 16'h1234));
        emit(itype_word(mips_pkg::OP_LUI, 0, 12, 16'hA5A5));
        emit(rtype_word(mips_pkg::FN_ADDU, 11, 12, 13, 0));
        emit(rtype_word(mips_pkg::FN_SUBU, 13, 8, 14, 0));
        emit(rtype_word(mips_pkg::FN_AND, 14, 10, 15, 0));
        emit(rtype_word(mips_pkg::FN_OR, 15, 12, 16, 0));
        emit(rtype_word(mips_pkg::FN_XOR, 16, 13, 17, 0));
        emit(rtype_word(mips_pkg::FN_SLTU, 9, 8, 18, 0));
        emit(rtype_word(mips_pkg::FN_SLL, 0, 17, 19, 4));
        emit(rtype_word(mips_pkg::FN_SRL, 0, 19, 20, 3));
        emit(rtype_word(mips_pkg::FN_ADDU, 20, 18, 2, 0));
        emit(rtype_word(mips_pkg::FN_JR, 0, 0, 0, 0));
        // ADDIU sign-extends and the logic ops zero-extend
        m[8]  = sext16(16'hFFF3);
        m[9]  = m[8] & zext16(16'h0FF0);
        m[10] = m[9] | zext16(16'h8001);
        m[11] = m[10] ^ zext16(16'h1234);
        m[12] = {16'hA5A5, 16'h0000};
        m[13] = m[11] + m[12];
        m[14] = m[13] - m[8];
        m[15] = m[14] & m[10];
        m[16] = m[15] | m[12];
        m[17] = m[16] ^ m[13];
        m[18] = (m[9] < m[8]) ? 32'd1 : 32'd0;
        m[19] = m[17] << 4;
        m[20] = m[19] >> 3;
        m[2]  = m[20] + m[18];
        apply_reset();
        run_to_halt(-1, 6'd0);
        check_value(m[2], register_v0);
        end_test();
    endtask

    task automatic store_and_load();
        logic [31:0] addr;
        logic [31:0] word;
        begin_test("load_store");
        load_store_program();
        addr = 32'h0000_0040 + sext16(16'h0008);
        word = {16'h1234, 16'h0000} | zext16(16'h5678);
        apply_reset();
        run_to_halt(-1, 6'd0);
        check_value(word, dmem[addr[7:2]]);
        check_value(word, register_v0);
        // One LW in the program
        check_value(32'd1, read_strobes);
        end_test();
    endtask

    task automatic branches_and_jumps();
        logic [31:0] flag;
        begin_test("control_flow");
        emit(itype_word(mips_pkg::OP_ADDIU, 0, 2, 16'd1));
        emit(itype_word(mips_pkg::OP_ADDIU, 0, 8, 16'd5));
        emit(itype_word(mips_pkg::OP_BEQ, 8, 8, 16'd1));
        emit(itype_word(mips_pkg::OP_ADDIU, 0, 2, 16'h0099));
        emit(itype_word(mips_pkg::OP_BNE, 8, 8, 16'd1));
        emit(itype_word(mips_pkg::OP_ADDIU, 2, 2, 16'd2));
        emit(jump_word(mips_pkg::OP_J, mips_pkg::RESET_VECTOR + 32'd32));
        emit(itype_word(mips_pkg::OP_ADDIU, 0, 2, 16'h0077));
        emit(jump_word(mips_pkg::OP_JAL, mips_pkg::RESET_VECTOR + 32'd40));
        emit(itype_word(mips_pkg::OP_ADDIU, 0, 2, 16'h0055));
        // Flag survives only if no skipped or slot word ran
        emit(itype_word(mips_pkg::OP_SW, 0, 2, 16'd0));
        emit(rtype_word(mips_pkg::FN_ADDU, 31, 0, 2, 0));
        emit(rtype_word(mips_pkg::FN_JR, 0, 0, 0, 0));
        flag = sext16(16'd1) + sext16(16'd2);
        apply_reset();
        run_to_halt(-1, 6'd0);
        check_value(flag, dmem[0]);
        check_value(mips_pkg::RESET_VECTOR + 32'd32 + 32'd4, register_v0);
        end_test();
    endtask

    task automatic clock_enable_stall();
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] ref_v0;
        begin_test("clock_enable");
        load_store_program();
        addr = 32'h0000_0040 + sext16(16'h0008);
        word = {16'h1234, 16'h0000} | zext16(16'h5678);
        apply_reset();
        run_to_halt(-1, 6'd0);
        ref_v0 = register_v0;
        check_value(word, ref_v0);
        // Stall holds the LW before it writes $2
        apply_reset();
        run_to_halt(4, addr[7:2]);
        check_value(ref_v0, register_v0);
        check_value(ref_v0, dmem[addr[7:2]]);
        end_test();
    endtask

    task automatic random_operands();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        begin_test("random_operands");
        for (int k = 0; k < 10; k++) begin
            a = next_random();
            b = next_random();
            clear_program();
            emit(itype_word(mips_pkg::OP_LUI, 0, 8, a[31:16]));
            emit(itype_word(mips_pkg::OP_ORI, 8, 8, a[15:0]));
            emit(itype_word(mips_pkg::OP_LUI, 0, 9, b[31:16]));
            emit(itype_word(mips_pkg::OP_ORI, 9, 9, b[15:0]));
            emit(rtype_word(mips_pkg::FN_ADDU, 8, 9, 10, 0));
            emit(rtype_word(mips_pkg::FN_XOR, 10, 9, 11, 0));
            emit(rtype_word(mips_pkg::FN_SUBU, 11, 8, 2, 0));
            emit(rtype_word(mips_pkg::FN_JR, 0, 0, 0, 0));
            expected = ((a + b) ^ b) - a;
            apply_reset();
            run_to_halt(-1, 6'd0);
            check_value(expected, register_v0);
        end
        end_test();
    endtask

    initial begin
        arst_n       = 1'b0;
        clk_enable   = 1'b1;
        rng_state    = 32'd12;
        prog_len     = 0;
        read_strobes = 0;
        test_errors  = 0;
        pass_count   = 0;
        fail_count   = 0;
        current_test = "none";
        clear_program();
        reset_and_halt();
        alu_instructions();
        store_and_load();
        branches_and_jumps();
        clock_enable_stall();
        random_operands();
        $display("tests passed %0d failed %0d, assertion failures %0d",
                 pass_count, fail_count, dut0.u_asserts.error_count);
        if (fail_count == 0 && dut0.u_asserts.error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out in test %s, the CPU never halted", current_test);
        $display("sim failed");
        $finish;
    end

endmodule

//--- files.f
hw/mips_pkg.sv
hw/mips_decode_if.sv
hw/mips_decoder.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_pc.sv
hw/mips_cpu_harvard.sv
testbench/tb_clock.sv
testbench/mips_asserts.sv
testbench/mips_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module mips_tb -f files.f -o mips_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/mips_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0
